// ==== runSim.sh ====
#!/bin/sh
# Build with Verilator, then run and search the log for the fail message
verilator --binary --timing --assert --top-module zknUnitTb -f zknUnit.f -o zknUnitSim \
   > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/zknUnitSim > sim.log 2>&1
grep -q "Errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation ended without a verdict, see sim.log"; exit 1; }
echo "Simulation passed"

// ==== src/aes32d.sv ====
module aes32d (
   input  logic [7:0]  sboxIn,
   input  logic        finalRound,
   output logic [31:0] result
);
   import zknPkg::*;

   logic [7:0]  sboxOut;
   logic [7:0]  mul9;
   logic [7:0]  mulB;
   logic [7:0]  mulD;
   logic [7:0]  mulE;
   logic [31:0] mixCol;

   // InvSubBytes on the selected byte
   aesInvSbox invSbox (
      .in  (sboxIn),
      .out (sboxOut)
   );

   // InvMixColumns coefficients
   assign mul9 = gfMul(sboxOut, 8'h09);
   assign mulB = gfMul(sboxOut, 8'h0b);
   assign mulD = gfMul(sboxOut, 8'h0d);
   assign mulE = gfMul(sboxOut, 8'h0e);

   // Top byte down is 0b, 0d, 09, 0e
   assign mixCol = {mulB, mulD, mul9, mulE};

   // Last round has no InvMixColumns
   assign result = finalRound ? {24'h000000, sboxOut} : mixCol;

endmodule

// ==== src/aes32e.sv ====
module aes32e (
   input  logic [7:0]  sboxIn,
   input  logic        finalRound,
   output logic [31:0] result
);
   import zknPkg::*;

   logic [7:0]  sboxOut;
   logic [7:0]  mul2;
   logic [7:0]  mul3;
   logic [31:0] mixCol;

   // SubBytes on the selected byte
   aesSbox sbox (
      .in  (sboxIn),
      .out (sboxOut)
   );

   // Column multiples for MixColumns
   assign mul2 = gfMul(sboxOut, 8'h02);
   assign mul3 = gfMul(sboxOut, 8'h03);

   // One input byte spreads over a full column
   // Top byte down is 3, 1, 1, 2
   assign mixCol = {mul3, sboxOut, sboxOut, mul2};

   // Final round skips MixColumns, byte lands in the low lane
   assign result = finalRound ? {24'h000000, sboxOut} : mixCol;

endmodule

// ==== src/aesInvSbox.sv ====
module aesInvSbox (
   input  logic [7:0] in,
   output logic [7:0] out
);
   import zknPkg::*;

   // Undo the affine map before inverting
   logic [7:0] preInv;

   // Inverse affine map
   // Rotations by 1, 3 and 6 with constant 0x05
   assign preInv = {in[6:0], in[7]}
                 ^ {in[4:0], in[7:5]}
                 ^ {in[1:0], in[7:2]}
                 ^ 8'h05;

   // Field inverse recovers the original byte
   assign out = gfInv(preInv);

endmodule

// ==== src/aesSbox.sv ====
module aesSbox (
   input  logic [7:0] in,
   output logic [7:0] out
);
   import zknPkg::*;

   // Multiplicative inverse first
   logic [7:0] inv;

   assign inv = gfInv(in);

   // Affine map
   // Each bit XORs with the four bits above it (cyclic), then add 0x63
   assign out = inv
              ^ {inv[6:0], inv[7]}
              ^ {inv[5:0], inv[7:6]}
              ^ {inv[4:0], inv[7:5]}
              ^ {inv[3:0], inv[7:4]}
              ^ 8'h63;

endmodule

// ==== src/zknPkg.sv ====
package zknPkg;

   ////////////////////
   // funct7 encodings
   ////////////////////

   // Operation field is funct7[4:0]
   // Byte select bs occupies funct7[6:5]
   localparam int FunctOpW = 5;

   // Bit 1 set marks a middle round with a mix step
   // Bit 2 set marks decrypt
   localparam logic [FunctOpW-1:0] OpEsi  = 5'b10001;
   localparam logic [FunctOpW-1:0] OpEsmi = 5'b10011;
   localparam logic [FunctOpW-1:0] OpDsi  = 5'b10101;
   localparam logic [FunctOpW-1:0] OpDsmi = 5'b10111;

   ////////////////////
   // GF(2^8) helpers
   ////////////////////

   // Field multiply modulo x^8 + x^4 + x^3 + x + 1
   function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] acc;
      logic [7:0] sh;
      acc = 8'h00;
      sh  = a;
      for (int i = 0; i < 8; i++) begin
         // Add the shifted multiplicand for every set bit of b
         if (b[i]) begin
            acc = acc ^ sh;
         end
         // Multiply by x, fold the carry back with 0x1b
         sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
      end
      return acc;
   endfunction

   // Field inverse as a^254
   // 254 = 2 + 4 + 8 + 16 + 32 + 64 + 128, so chain squares and multiply them in
   // Zero has no inverse and falls out as zero
   function automatic logic [7:0] gfInv(input logic [7:0] a);
      logic [7:0] sq;
      logic [7:0] acc;
      sq  = a;
      acc = 8'h01;
      for (int i = 1; i < 8; i++) begin
         // sq holds a^(2^i) after this step
         sq  = gfMul(sq, sq);
         acc = gfMul(acc, sq);
      end
      return acc;
   endfunction

endpackage

// ==== src/zknUnit.sv ====
module zknUnit #(
   parameter bit ZkndSupported = 1'b1,
   parameter bit ZkneSupported = 1'b1
) (
   input  logic        clk,
   input  logic        arstN,
   input  logic        valid,
   input  logic [6:0]  funct7,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   output logic [31:0] result,
   output logic        resultValid,
   output logic        illegal
);
   import zknPkg::*;

   logic [FunctOpW-1:0] op;
   logic [1:0]          bs;
   logic                isEnc;
   logic                isDec;
   logic                supported;
   logic [31:0]         zkndeResult;

   ////////////////////
   // Decode
   ////////////////////

   // funct7 splits into byte select and operation
   assign bs = funct7[6:5];
   assign op = funct7[FunctOpW-1:0];

   // Exact match against the four defined codes
   assign isEnc = (op == OpEsi) || (op == OpEsmi);
   assign isDec = (op == OpDsi) || (op == OpDsmi);

   // Legal only when the matching extension is in this build
   assign supported = (isEnc && ZkneSupported) || (isDec && ZkndSupported);

   // Datapath, single cycle combinational
   // op[1] clear means final round, op[2] set means decrypt
   zknde32 #(
      .ZkndSupported (ZkndSupported),
      .ZkneSupported (ZkneSupported)
   ) zknde (
      .A           (rs1),
      .B           (rs2),
      .bs          (bs),
      .finalRound  (~op[1]),
      .decrypt     (op[2]),
      .zkndeResult (zkndeResult)
   );

   ////////////////////
   // Output register
   ////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         result      <= 32'h0;
         resultValid <= 1'b0;
         illegal     <= 1'b0;
      end else begin
         // Exactly one pulse per valid, one cycle later
         resultValid <= valid & supported;
         illegal     <= valid & ~supported;
         // Result holds its value through illegal and idle cycles
         if (valid && supported) begin
            result <= zkndeResult;
         end
      end
   end

endmodule

// ==== src/zknde32.sv ====
module zknde32 #(
   parameter bit ZkndSupported = 1'b1,
   parameter bit ZkneSupported = 1'b1
) (
   input  logic [31:0] A,
   input  logic [31:0] B,
   input  logic [1:0]  bs,
   input  logic        finalRound,
   input  logic        decrypt,
   output logic [31:0] zkndeResult
);

   logic [7:0]  sboxIn;
   logic [31:0] colE;
   logic [31:0] colD;
   logic [31:0] rotIn;
   logic [31:0] rotOut;

   // Byte bs of rs2 feeds both column paths
   assign sboxIn = B[{bs, 3'b000} +: 8];

   ////////////////////
   // Column paths
   ////////////////////

   // Each path exists only when its extension is built
   if (ZkneSupported) begin : genEnc
      aes32e enc (.sboxIn(sboxIn), .finalRound(finalRound), .result(colE));
   end else begin : genNoEnc
      assign colE = 32'h0;
   end

   if (ZkndSupported) begin : genDec
      aes32d dec (.sboxIn(sboxIn), .finalRound(finalRound), .result(colD));
   end else begin : genNoDec
      assign colD = 32'h0;
   end

   // With one path built the other column is zero, so OR picks it
   if (ZkndSupported && ZkneSupported) begin : genBoth
      assign rotIn = decrypt ? colD : colE;
   end else begin : genOne
      assign rotIn = colD | colE;
   end

   ////////////////////
   // Rotate and combine
   ////////////////////

   // Rotate left by 8*bs so the column lines up with the state word
   always_comb begin
      case (bs)
         2'd0:    rotOut = rotIn;
         2'd1:    rotOut = {rotIn[23:0], rotIn[31:24]};
         2'd2:    rotOut = {rotIn[15:0], rotIn[31:16]};
         default: rotOut = {rotIn[7:0], rotIn[31:8]};
      endcase
   end

   // Accumulate into rs1
   assign zkndeResult = A ^ rotOut;

endmodule

// ==== tests/zknUnitTb.sv ====
module zknUnitTb;
   timeunit 1ns;
   timeprecision 100ps;
   import zknPkg::*;

   localparam int MaxCycles  = 5000;
   localparam int DrainLimit = 20;

   logic        clk;
   logic        arstN;
   logic        valid;
   logic [6:0]  funct7;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic [31:0] result;
   logic        resultValid;
   logic        illegal;

   integer      seed = 32'h102ef952;
   int          cycleCount = 0;
   int          errorCount = 0;
   logic [31:0] heldResult = 32'h0;
   logic [7:0]  sboxTable [256];
   logic [7:0]  invSboxTable [256];

   // Scoreboard queues with one entry per issued valid
   bit          expKind [$];
   logic [31:0] expValue [$];
   int          expDue [$];

   zknUnit #(.ZkndSupported(1'b1), .ZkneSupported(1'b1)) uut (
      .clk(clk), .arstN(arstN), .valid(valid), .funct7(funct7), .rs1(rs1), .rs2(rs2),
      .result(result), .resultValid(resultValid), .illegal(illegal)
   );

   bind zknUnit zknUnitProps props (
      .clk(clk), .arstN(arstN), .valid(valid), .resultValid(resultValid), .illegal(illegal)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycleCount <= cycleCount + 1;

   ////////////////////
   // Error handling
   ////////////////////

   task automatic abortRun();
      errorCount++;
      $display("Errors found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic reportProblem(input string what);
      $display("Error at %0t ns: %s", $time, what);
      abortRun();
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
         abortRun();
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   function automatic logic [31:0] randomWord();
      return $random(seed);
   endfunction

   // Multiply by x in the AES field
   function automatic logic [7:0] xtime(input logic [7:0] b);
      return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   // Generator walk over the field
   // p steps by 3 and q by the inverse of 3
   task automatic buildTables();
      logic [7:0] p;
      logic [7:0] q;
      logic [7:0] x;
      p = 8'h01;
      q = 8'h01;
      for (int i = 0; i < 255; i++) begin
         p = p ^ {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
         q = q ^ {q[6:0], 1'b0};
         q = q ^ {q[5:0], 2'b00};
         q = q ^ {q[3:0], 4'h0};
         q = q ^ (q[7] ? 8'h09 : 8'h00);
         // q now holds 1/p
         // Affine map on the inverse
         x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
         sboxTable[p] = x ^ 8'h63;
      end
      sboxTable[0] = 8'h63;
      // Inverse table by reverse lookup
      for (int i = 0; i < 256; i++) begin
         invSboxTable[sboxTable[i]] = i[7:0];
      end
   endtask

   function automatic bit isLegalOp(input logic [4:0] op);
      return (op == OpEsi) || (op == OpEsmi) || (op == OpDsi) || (op == OpDsmi);
   endfunction

   function automatic logic [31:0] expectedValue(input logic [6:0] f7, input logic [31:0] a,
                                                 input logic [31:0] b);
      logic [1:0]  bs;
      logic [31:0] shifted;
      logic [7:0]  s;
      logic [7:0]  x2;
      logic [7:0]  x4;
      logic [7:0]  x8;
      logic [31:0] col;
      bs = f7[6:5];
      shifted = b >> (8 * bs);
      s = f7[2] ? invSboxTable[shifted[7:0]] : sboxTable[shifted[7:0]];
      // Multiples by doubling
      x2 = xtime(s);
      x4 = xtime(x2);
      x8 = xtime(x4);
      if (!f7[1]) begin
         col = {24'h000000, s};
      end else if (f7[2]) begin
         // Coefficients 0b, 0d, 09, 0e
         col = {x8 ^ x2 ^ s, x8 ^ x4 ^ s, x8 ^ s, x8 ^ x4 ^ x2};
      end else begin
         // Coefficients 3, 1, 1, 2
         col = {x2 ^ s, s, s, x2};
      end
      repeat (bs) col = {col[23:0], col[31:24]};
      return a ^ col;
   endfunction

   function automatic logic [4:0] pickUndefinedOp();
      logic [31:0] r;
      r = randomWord();
      while (isLegalOp(r[4:0])) r = randomWord();
      return r[4:0];
   endfunction

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic issueOp(input logic [6:0] f7, input logic [31:0] a, input logic [31:0] b);
      @(negedge clk);
      valid  = 1'b1;
      funct7 = f7;
      rs1    = a;
      rs2    = b;
      expDue.push_back(cycleCount + 1);
      expKind.push_back(!isLegalOp(f7[4:0]));
      expValue.push_back(isLegalOp(f7[4:0]) ? expectedValue(f7, a, b) : 32'h0);
   endtask

   // Idle cycle with noise on the operands
   task automatic idleCycle();
      logic [31:0] r;
      r = randomWord();
      @(negedge clk);
      valid  = 1'b0;
      funct7 = r[6:0];
      rs1    = randomWord();
      rs2    = randomWord();
   endtask

   task automatic waitForDrain();
      int waited;
      waited = 0;
      while (expDue.size() != 0 && waited < DrainLimit) begin
         @(negedge clk);
         waited++;
      end
      if (expDue.size() != 0) reportProblem("pulses still missing after the drain timeout");
   endtask

   ////////////////////
   // Scoreboard
   ////////////////////

   always @(negedge clk) begin
      bit          kind;
      logic [31:0] value;
      if (arstN) begin
         if (resultValid || illegal) begin
            if (expDue.size() == 0) begin
               reportProblem("output pulse with no instruction in flight");
            end
            checkValue("pulse cycle", cycleCount, expDue.pop_front());
            kind  = expKind.pop_front();
            value = expValue.pop_front();
            checkValue("resultValid", 32'(resultValid), 32'(!kind));
            checkValue("illegal", 32'(illegal), 32'(kind));
            if (!kind) heldResult = value;
         end else if (expDue.size() != 0 && expDue[0] <= cycleCount) begin
            reportProblem("instruction produced no pulse one cycle after its valid");
         end
         // Result must hold between pulses and across illegal ones
         checkValue("result", result, heldResult);
      end
   end

   // Watchdog bounded in clock cycles
   initial begin
      for (int i = 0; i < MaxCycles; i++) @(posedge clk);
      reportProblem("simulation did not finish within the cycle limit");
   end

   initial begin
      logic [31:0] r;
      int          burstLen;
      valid  = 1'b0;
      funct7 = 7'h00;
      rs1    = 32'h0;
      rs2    = 32'h0;
      arstN  = 1'b0;
      buildTables();
      // Known values from the AES standard guard the model
      checkValue("model sbox[53]", 32'(sboxTable[8'h53]), 32'h000000ed);
      checkValue("model invSbox[ed]", 32'(invSboxTable[8'hed]), 32'h00000053);
      repeat (2) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;

      // Outputs right after reset
      @(negedge clk);
      checkValue("resultValid", 32'(resultValid), 32'h0);
      checkValue("illegal", 32'(illegal), 32'h0);
      checkValue("result", result, 32'h0);

      // Final rounds over every byte select
      for (int bs = 0; bs < 4; bs++) begin
         issueOp({bs[1:0], OpEsi}, randomWord(), randomWord());
         issueOp({bs[1:0], OpDsi}, randomWord(), randomWord());
      end
      idleCycle();

      // Middle rounds, random mix
      for (int i = 0; i < 200; i++) begin
         r = randomWord();
         issueOp({r[2:1], r[0] ? OpEsmi : OpDsmi}, randomWord(), randomWord());
         if (r[5:3] == 3'd0) idleCycle();
      end
      idleCycle();

      // Undefined operations after a known result
      for (int i = 0; i < 8; i++) begin
         r = randomWord();
         issueOp({r[1:0], OpEsmi}, randomWord(), randomWord());
         issueOp({r[3:2], pickUndefinedOp()}, randomWord(), randomWord());
         if (r[4]) idleCycle();
      end

      // Bursts with random gaps
      for (int burst = 0; burst < 30; burst++) begin
         r = randomWord();
         burstLen = 1 + r[2:0];
         repeat (burstLen) begin
            r = randomWord();
            if (r[9:7] == 3'd0) begin
               issueOp({r[6:5], pickUndefinedOp()}, randomWord(), randomWord());
            end else begin
               // Any of the four defined codes
               issueOp({r[6:5], 2'b10, r[2], r[1], 1'b1}, randomWord(), randomWord());
            end
         end
         repeat (r[4:3]) idleCycle();
      end

      idleCycle();
      waitForDrain();
      idleCycle();
      if (errorCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== tests/zknUnit_props.sv ====
module zknUnitProps (
   input logic clk,
   input logic arstN,
   input logic valid,
   input logic resultValid,
   input logic illegal
);
   timeunit 1ns;
   timeprecision 100ps;

   ////////////////////
   // Output pulses
   ////////////////////

   // A result and an illegal flag never share a cycle
   resultIllegalExclusive: assert property (
      @(posedge clk) disable iff (!arstN) !(resultValid && illegal)
   ) else $error("resultValid and illegal high together");

   // Every pulse traces back to a valid one cycle earlier
   pulseFollowsValid: assert property (
      @(posedge clk) disable iff (!arstN) (resultValid || illegal) |-> $past(valid)
   ) else $error("output pulse without a valid in the cycle before");

   // Outputs stay quiet while reset is held
   quietInReset: assert property (
      @(posedge clk) !arstN |-> (!resultValid && !illegal)
   ) else $error("output pulse during reset");

endmodule

// ==== zknUnit.f ====
src/zknPkg.sv
src/aesSbox.sv
src/aesInvSbox.sv
src/aes32e.sv
src/aes32d.sv
src/zknde32.sv
src/zknUnit.sv
tests/zknUnit_props.sv
tests/zknUnitTb.sv
